// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tournament predictor testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f vlog.f --top-module tb_tournament_bp -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    echo "RESULT: PASS"
    exit 0
else
    echo "RESULT: FAIL"
    exit 1
fi

// ==== source/bimodal_predictor.sv ====
`timescale 1ns/1ps

module bimodal_predictor import bp_cfg_pkg::*, bp_if_pkg::*; #(
    parameter int BIM_INDEX_BITS = 10
) (
    input  logic         clk,
    input  logic         rst_n,

    input  bp_pred_req_t pred_req,
    input  bp_update_t   upd,

    output logic         pred_taken,
    output logic         upd_dir
);

    logic [BIM_INDEX_BITS-1:0] pred_index;
    logic [BIM_INDEX_BITS-1:0] upd_index;
    ctr2_t                     pred_ctr;
    ctr2_t                     upd_ctr;

    assign pred_index = pred_req.pc[BIM_INDEX_BITS+1:2]; // word aligned pc.
    assign upd_index  = upd.pc[BIM_INDEX_BITS+1:2];

    sat_counter_table #(
        .INDEX_BITS (BIM_INDEX_BITS)
    ) bht_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_a_index (pred_index),
        .rd_b_index (upd_index),
        .rd_a_ctr   (pred_ctr),
        .rd_b_ctr   (upd_ctr),
        .wr_en      (upd.valid),
        .wr_index   (upd_index),
        .wr_inc     (upd.taken)
    );

    assign upd_dir = ctr_dir(upd_ctr); // pre-training direction.

    always_ff @(posedge clk) begin
        if (pred_req.valid) begin
            pred_taken <= ctr_dir(pred_ctr);
        end
    end

endmodule

// ==== source/bp_cfg_pkg.sv ====
package bp_cfg_pkg;

    // 2-bit saturating counter.
    // msb set means taken, or prefer gshare in the chooser.
    typedef logic [1:0] ctr2_t;

    // weakly not taken, or weakly prefer bimodal.
    localparam ctr2_t CTR_RESET = 2'b01;

    // saturation limits.
    localparam ctr2_t CTR_MAX = 2'b11;
    localparam ctr2_t CTR_MIN = 2'b00;

    // direction encoded by a counter.
    function automatic logic ctr_dir(input ctr2_t ctr);
        return ctr[1];
    endfunction

endpackage

// ==== source/bp_if_pkg.sv ====
package bp_if_pkg;

    localparam int PC_BITS   = 32;
    localparam int HIST_BITS = 10; // also the gshare index width.

    // fetch side request.
    typedef struct packed {
        logic               valid;
        logic [PC_BITS-1:0] pc;
    } bp_pred_req_t;

    // answer to fetch, one cycle after the request.
    typedef struct packed {
        logic                 valid;
        logic                 taken;
        logic [HIST_BITS-1:0] hist; // history used for this prediction.
    } bp_pred_resp_t;

    // resolved branch from execute.
    typedef struct packed {
        logic                 valid;
        logic [PC_BITS-1:0]   pc;
        logic [HIST_BITS-1:0] hist;  // snapshot returned with the prediction.
        logic                 taken; // resolved outcome.
    } bp_update_t;

endpackage

// ==== source/choice_predictor.sv ====
`timescale 1ns/1ps

module choice_predictor import bp_cfg_pkg::*, bp_if_pkg::*; #(
    parameter int CHOICE_INDEX_BITS = 10
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  bp_pred_req_t         pred_req,
    input  bp_update_t           upd,

    input  logic                 gshare_taken,
    input  logic                 bimodal_taken,
    input  logic                 gshare_upd_dir,
    input  logic                 bimodal_upd_dir,
    input  logic [HIST_BITS-1:0] pred_hist,

    output bp_pred_resp_t        pred_resp
);

    logic [CHOICE_INDEX_BITS-1:0] pred_index;
    logic [CHOICE_INDEX_BITS-1:0] upd_index;
    ctr2_t                        pred_ctr;
    logic                         disagree;
    logic                         gshare_right;
    logic                         valid_q;
    logic                         use_gshare_q;

    assign pred_index = pred_req.pc[CHOICE_INDEX_BITS+1:2];
    assign upd_index  = upd.pc[CHOICE_INDEX_BITS+1:2];

    // train only when exactly one component was right.
    assign disagree     = gshare_upd_dir != bimodal_upd_dir;
    assign gshare_right = gshare_upd_dir == upd.taken;

    sat_counter_table #(
        .INDEX_BITS (CHOICE_INDEX_BITS)
    ) chooser_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_a_index (pred_index),
        .rd_b_index (upd_index),
        .rd_a_ctr   (pred_ctr),
        .rd_b_ctr   (),
        .wr_en      (upd.valid && disagree),
        .wr_index   (upd_index),
        .wr_inc     (gshare_right) // up means lean to gshare.
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pred_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pred_req.valid) begin
            use_gshare_q <= ctr_dir(pred_ctr);
        end
    end

    // component outputs are registered in the same cycle as the choice.
    always_comb begin
        pred_resp.valid = valid_q;
        pred_resp.taken = use_gshare_q ? gshare_taken : bimodal_taken;
        pred_resp.hist  = pred_hist;
    end

endmodule

// ==== source/gshare_predictor.sv ====
`timescale 1ns/1ps

module gshare_predictor import bp_cfg_pkg::*, bp_if_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,

    input  bp_pred_req_t         pred_req,
    input  bp_update_t           upd,

    output logic                 pred_taken,
    output logic [HIST_BITS-1:0] pred_hist,
    output logic                 upd_dir
);

    logic [HIST_BITS-1:0] hist_q;  // committed global history.
    logic [HIST_BITS-1:0] pred_index;
    logic [HIST_BITS-1:0] upd_index;
    ctr2_t                pred_ctr;
    ctr2_t                upd_ctr;

    // pc bits above the word offset hashed with history.
    assign pred_index = pred_req.pc[HIST_BITS+1:2] ^ hist_q;
    assign upd_index  = upd.pc[HIST_BITS+1:2] ^ upd.hist; // snapshot from fetch time.

    sat_counter_table #(
        .INDEX_BITS (HIST_BITS)
    ) pht_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_a_index (pred_index),
        .rd_b_index (upd_index),
        .rd_a_ctr   (pred_ctr),
        .rd_b_ctr   (upd_ctr),
        .wr_en      (upd.valid),
        .wr_index   (upd_index),
        .wr_inc     (upd.taken)
    );

    // what gshare says for the resolving branch, before training.
    assign upd_dir = ctr_dir(upd_ctr);

    // non-speculative history, shifts only on resolved branches.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hist_q <= '0;
        end else if (upd.valid) begin
            hist_q <= {hist_q[HIST_BITS-2:0], upd.taken}; // newest at bit 0.
        end
    end

    // prediction and the history it used.
    always_ff @(posedge clk) begin
        if (pred_req.valid) begin
            pred_taken <= ctr_dir(pred_ctr);
            pred_hist  <= hist_q;
        end
    end

endmodule

// ==== source/sat_counter_table.sv ====
`timescale 1ns/1ps

module sat_counter_table import bp_cfg_pkg::*; #(
    parameter int INDEX_BITS = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic [INDEX_BITS-1:0] rd_a_index,
    input  logic [INDEX_BITS-1:0] rd_b_index,
    output ctr2_t                 rd_a_ctr,
    output ctr2_t                 rd_b_ctr,

    input  logic                  wr_en,
    input  logic [INDEX_BITS-1:0] wr_index,
    input  logic                  wr_inc
);

    localparam int ENTRIES = 2 ** INDEX_BITS;

    ctr2_t table_q [ENTRIES];
    ctr2_t wr_cur;
    ctr2_t wr_next;

    // both reads see the state before any write at this edge.
    assign rd_a_ctr = table_q[rd_a_index];
    assign rd_b_ctr = table_q[rd_b_index];

    assign wr_cur = table_q[wr_index];

    always_comb begin
        wr_next = wr_cur;
        if (wr_inc) begin
            if (wr_cur != CTR_MAX) begin
                wr_next = wr_cur + 2'd1; // step toward taken.
            end
        end else begin
            if (wr_cur != CTR_MIN) begin
                wr_next = wr_cur - 2'd1; // step toward not taken.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                table_q[i] <= CTR_RESET;
            end
        end else if (wr_en) begin
            table_q[wr_index] <= wr_next;
        end
    end

endmodule

// ==== source/tournament_bp_top.sv ====
`timescale 1ns/1ps

module tournament_bp_top import bp_if_pkg::*; #(
    parameter int BIM_INDEX_BITS    = 10,
    parameter int CHOICE_INDEX_BITS = 10
) (
    input  logic          clk,
    input  logic          rst_n,

    input  bp_pred_req_t  pred_req,  // from fetch.
    input  bp_update_t    upd,       // from execute.
    output bp_pred_resp_t pred_resp
);

    logic                 gshare_taken;
    logic                 gshare_upd_dir;
    logic [HIST_BITS-1:0] gshare_hist;
    logic                 bimodal_taken;
    logic                 bimodal_upd_dir;

    gshare_predictor gshare_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .pred_req   (pred_req),
        .upd        (upd),
        .pred_taken (gshare_taken),
        .pred_hist  (gshare_hist),
        .upd_dir    (gshare_upd_dir)
    );

    bimodal_predictor #(
        .BIM_INDEX_BITS (BIM_INDEX_BITS)
    ) bimodal_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .pred_req   (pred_req),
        .upd        (upd),
        .pred_taken (bimodal_taken),
        .upd_dir    (bimodal_upd_dir)
    );

    choice_predictor #(
        .CHOICE_INDEX_BITS (CHOICE_INDEX_BITS)
    ) choice_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .pred_req        (pred_req),
        .upd             (upd),
        .gshare_taken    (gshare_taken),
        .bimodal_taken   (bimodal_taken),
        .gshare_upd_dir  (gshare_upd_dir),
        .bimodal_upd_dir (bimodal_upd_dir),
        .pred_hist       (gshare_hist),
        .pred_resp       (pred_resp)
    );

endmodule

// ==== verif/tb_tournament_bp.sv ====
`timescale 1ns/1ps

module tb_tournament_bp import bp_cfg_pkg::*, bp_if_pkg::*; ();

    localparam int IDX_BITS    = 10;            // default index widths of the top.
    localparam int ENTRIES     = 1 << IDX_BITS;
    localparam int RANDOM_OPS  = 300;
    localparam int TOTAL_OPS   = 410;           // directed plus random plus drain.
    localparam int WATCHDOG_NS = (TOTAL_OPS + 100) * 10 * 4;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam logic [HIST_BITS-1:0] PATTERN = 10'b11_0100_1110;
    localparam logic [PC_BITS-1:0] PC_POOL [4] = '{
        32'h0000_1000, 32'h0000_1004, 32'h0000_2000, 32'h0000_1f08  // 1000 and 2000 alias.
    };

    logic          clk;
    logic          rst_n;
    bp_pred_req_t  pred_req;
    bp_update_t    upd;
    bp_pred_resp_t pred_resp;

    // reference model state.
    ctr2_t                gsh_m [ENTRIES];
    ctr2_t                bim_m [ENTRIES];
    ctr2_t                cho_m [ENTRIES];
    logic [HIST_BITS-1:0] hist_m;

    logic [31:0] lfsr_state;
    int          checks;
    int          errors;

    tournament_bp_top tournament_bp_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pred_req  (pred_req),
        .upd       (upd),
        .pred_resp (pred_resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic ctr2_t sat_step(input ctr2_t c, input logic up);
        if (up) begin
            return (c == CTR_MAX) ? c : c + 2'd1;
        end
        return (c == CTR_MIN) ? c : c - 2'd1;
    endfunction

    function automatic logic model_taken(input logic [PC_BITS-1:0] pc);
        logic [IDX_BITS-1:0] idx;
        logic                g_dir;
        logic                b_dir;
        idx   = pc[IDX_BITS+1:2];
        g_dir = gsh_m[idx ^ hist_m][1];
        b_dir = bim_m[idx][1];
        return cho_m[idx][1] ? g_dir : b_dir; // msb set prefers gshare.
    endfunction

    function automatic void model_update(input logic [PC_BITS-1:0] pc,
                                         input logic [HIST_BITS-1:0] h,
                                         input logic taken);
        logic [IDX_BITS-1:0] idx;
        logic [IDX_BITS-1:0] g_idx;
        logic                g_dir;
        logic                b_dir;
        idx   = pc[IDX_BITS+1:2];
        g_idx = idx ^ h;
        g_dir = gsh_m[g_idx][1];
        b_dir = bim_m[idx][1];
        if (g_dir != b_dir) begin
            cho_m[idx] = sat_step(cho_m[idx], g_dir == taken);
        end
        gsh_m[g_idx] = sat_step(gsh_m[g_idx], taken);
        bim_m[idx]   = sat_step(bim_m[idx], taken);
        hist_m       = {hist_m[HIST_BITS-2:0], taken}; // committed history only.
    endfunction

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    // all drive tasks start and end on a falling edge.
    task automatic do_predict(input logic [PC_BITS-1:0] pc, output bp_pred_resp_t resp);
        pred_req.valid = 1'b1;
        pred_req.pc    = pc;
        @(posedge clk);
        @(negedge clk);
        resp           = pred_resp;
        pred_req.valid = 1'b0;
    endtask

    task automatic do_update(input logic [PC_BITS-1:0] pc, input logic [HIST_BITS-1:0] h,
                             input logic taken);
        upd.valid = 1'b1;
        upd.pc    = pc;
        upd.hist  = h;
        upd.taken = taken;
        @(posedge clk);
        @(negedge clk);
        upd.valid = 1'b0;
        model_update(pc, h, taken);
    endtask

    task automatic predict_check(input logic [PC_BITS-1:0] pc, output bp_pred_resp_t resp);
        logic                 exp_taken;
        logic [HIST_BITS-1:0] exp_hist;
        exp_taken = model_taken(pc);
        exp_hist  = hist_m;
        do_predict(pc, resp);
        check_eq("pred_resp.valid", 32'(resp.valid), 32'd1);
        check_eq("pred_resp.taken", 32'(resp.taken), 32'(exp_taken));
        check_eq("pred_resp.hist", 32'(resp.hist), 32'(exp_hist));
    endtask

    task automatic after_reset_test();
        bp_pred_resp_t resp;
        for (int i = 0; i < 3; i++) begin
            predict_check(PC_POOL[i] + 32'h40, resp);
            check_eq("pred_resp.taken", 32'(resp.taken), 32'd0);
            check_eq("pred_resp.hist", 32'(resp.hist), 32'd0);
        end
        @(posedge clk);
        @(negedge clk);
        check_eq("pred_resp.valid", 32'(pred_resp.valid), 32'd0); // idle cycle.
    endtask

    task automatic bimodal_test();
        bp_pred_resp_t        resp;
        logic [HIST_BITS-1:0] snap;
        predict_check(32'h0000_0100, resp);
        check_eq("pred_resp.taken", 32'(resp.taken), 32'd0);
        snap = resp.hist; // gshare trains in step with bimodal, chooser stays put.
        do_update(32'h0000_0100, snap, 1'b1);
        predict_check(32'h0000_0100, resp);
        check_eq("pred_resp.taken", 32'(resp.taken), 32'd1);
        repeat (3) do_update(32'h0000_0100, snap, 1'b1);
        do_update(32'h0000_0100, snap, 1'b0);
        predict_check(32'h0000_0100, resp);
        check_eq("pred_resp.taken", 32'(resp.taken), 32'd1); // saturated at 11.
        do_update(32'h0000_0100, snap, 1'b0);
        predict_check(32'h0000_0100, resp);
        check_eq("pred_resp.taken", 32'(resp.taken), 32'd0);
    endtask

    task automatic history_test();
        bp_pred_resp_t        resp;
        logic [HIST_BITS-1:0] old_snap;
        for (int i = HIST_BITS - 1; i >= 0; i--) begin
            do_update(32'h0000_0200, hist_m, PATTERN[i]);
        end
        predict_check(32'h0000_0400, resp);
        check_eq("pred_resp.hist", 32'(resp.hist), 32'(PATTERN)); // newest at bit 0.
        old_snap = resp.hist;
        repeat (3) do_update(32'h0000_0200, hist_m, 1'b1);
        repeat (2) do_update(32'h0000_0400, hist_m, 1'b0);
        // stale snapshot trains the entry it indexes.
        repeat (2) do_update(32'h0000_0400, old_snap, 1'b1);
        do_update(32'h0000_0400, hist_m, 1'b0); // components disagree, gshare right.
        for (int i = HIST_BITS - 1; i >= 0; i--) begin
            do_update(32'h0000_0200, hist_m, old_snap[i]);
        end
        predict_check(32'h0000_0400, resp);
        check_eq("pred_resp.hist", 32'(resp.hist), 32'(old_snap));
        check_eq("pred_resp.taken", 32'(resp.taken), 32'd1); // only the stale entry says taken.
    endtask

    task automatic chooser_test();
        bp_pred_resp_t resp;
        logic          outcome;
        for (int i = 0; i < 24; i++) begin
            outcome = (i % 2 == 0);
            predict_check(32'h0000_0a00, resp);
            if (i >= 20) begin
                check_eq("pred_resp.taken", 32'(resp.taken), 32'(outcome)); // gshare learned.
            end
            do_update(32'h0000_0a00, resp.hist, outcome);
        end
    endtask

    task automatic same_cycle_test();
        bp_pred_resp_t        resp;
        logic                 exp_taken;
        logic [HIST_BITS-1:0] exp_hist;
        logic [HIST_BITS-1:0] snap;
        snap = hist_m; // both updates hit one gshare entry.
        do_update(32'h0000_0c00, snap, 1'b1);
        exp_taken      = model_taken(32'h0000_0c00);
        exp_hist       = hist_m;
        pred_req.valid = 1'b1;
        pred_req.pc    = 32'h0000_0c00;
        upd.valid      = 1'b1;
        upd.pc         = 32'h0000_0c00;
        upd.hist       = snap;
        upd.taken      = 1'b0;
        @(posedge clk);
        @(negedge clk);
        resp           = pred_resp;
        pred_req.valid = 1'b0;
        upd.valid      = 1'b0;
        model_update(32'h0000_0c00, snap, 1'b0);
        check_eq("pred_resp.taken", 32'(resp.taken), 32'(exp_taken)); // pre-update state.
        check_eq("pred_resp.hist", 32'(resp.hist), 32'(exp_hist));
        predict_check(32'h0000_0c00, resp);
    endtask

    task automatic random_test();
        bp_pred_resp_t        resp;
        logic [PC_BITS-1:0]   pend_pc [$];
        logic [HIST_BITS-1:0] pend_hist [$];
        logic [PC_BITS-1:0]   pc;
        logic [31:0]          bits;
        int                   ops;
        ops = 0;
        while (ops < RANDOM_OPS) begin
            bits = rand_bits(2);
            pc   = PC_POOL[bits[1:0]];
            predict_check(pc, resp);
            pend_pc.push_back(pc);
            pend_hist.push_back(resp.hist);
            ops++;
            if (rand_bits(1) != 0 || pend_pc.size() > 3) begin
                bits = rand_bits(1);
                do_update(pend_pc.pop_front(), pend_hist.pop_front(), bits[0]);
                ops++;
            end
        end
        while (pend_pc.size() > 0) begin
            bits = rand_bits(1);
            do_update(pend_pc.pop_front(), pend_hist.pop_front(), bits[0]);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        pred_req   = '0;
        upd        = '0;
        lfsr_state = 32'hea1c;
        checks     = 0;
        errors     = 0;
        hist_m     = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            gsh_m[i] = CTR_RESET;
            bim_m[i] = CTR_RESET;
            cho_m[i] = CTR_RESET;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        after_reset_test();
        bimodal_test();
        history_test();
        chooser_test();
        same_cycle_test();
        random_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
source/bp_cfg_pkg.sv
source/bp_if_pkg.sv
source/sat_counter_table.sv
source/gshare_predictor.sv
source/bimodal_predictor.sv
source/choice_predictor.sv
source/tournament_bp_top.sv
verif/tb_tournament_bp.sv
